/* core_chk.sv */
`timescale 1ns/10ps
module core_chk import cpu_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      mem_req,
    input logic      mem_ack,
    input addr_t     mem_addr,
    input logic      retire_valid,
    input reg_addr_t retire_rd
);

    // four-phase rule on the external port
    a_req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) |-> !mem_ack)
        else $error("mem_req rose while mem_ack high");

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && $past(mem_req) |-> $stable(mem_addr))
        else $error("mem_addr changed during a request");

    a_ack_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && $past(mem_ack) |-> mem_ack)
        else $error("mem_ack fell while mem_req high");

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> mem_addr[31:2] < mem_words)
        else $error("mem_addr outside the memory image");

    a_retire_rd: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_rd != '0)
        else $error("retire to x0");

endmodule

bind core_top core_chk u_chk (.*);

/* core_tb.sv */
`timescale 1ns/10ps
module core_tb import cpu_pkg::*; ();

    logic      clk;
    logic      rst;
    logic      mem_ack;
    word_t     mem_rdata;
    logic      mem_req;
    logic      mem_we;
    addr_t     mem_addr;
    word_t     mem_wdata;
    logic      retire_valid;
    addr_t     retire_pc;
    reg_addr_t retire_rd;
    word_t     retire_data;

    word_t  img [mem_words];         // program and data image
    word_t  mem [mem_words];         // memory behind the port
    word_t  model_mem [mem_words];   // reference memory
    word_t  exp_pc [$];
    word_t  exp_rd [$];
    word_t  exp_data [$];
    integer seed = 32'h8c24;
    integer delay = -1;
    int     n_prog;
    int     n_exp;
    int     exp_idx;
    int     errors;
    int     cycles;

    core_top uut (
        .clk(clk), .rst(rst), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // rv32i encoders
    function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic inst_t enc_i(logic [6:0] op, logic [2:0] f3, int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic inst_t enc_s(int rs2, int rs1, int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic inst_t enc_b(logic [2:0] f3, int rs1, int rs2, int imm);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic inst_t enc_j(int rd, int imm);
        logic [20:0] i;
        i = 21'(imm);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic emit(input inst_t w);
        img[n_prog] = w;
        n_prog++;
    endtask

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // architectural model that steps until the self jump at the end
    function automatic int run_model();
        word_t regs [32];
        addr_t pc;
        inst_t w;
        word_t a, b, res, imm;
        int    rd;
        int    count;
        logic  wr;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < mem_words; i++)
            model_mem[i] = img[i];
        pc    = reset_pc;
        count = 0;
        for (int step = 0; step < 2000; step++) begin
            w   = model_mem[pc[9:2]];
            rd  = int'(w[11:7]);
            a   = regs[w[19:15]];
            b   = regs[w[24:20]];
            imm = {{20{w[31]}}, w[31:20]};
            wr  = 1'b1;
            res = '0;
            case (w[6:0])
                7'b0110011: case (w[14:12])
                    3'b000:  res = w[30] ? a - b : a + b;
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
                7'b0010011: res = a + imm;
                7'b0110111: res = {w[31:12], 12'h000};
                7'b0000011: res = model_mem[8'((a + imm) >> 2)];
                7'b0100011: begin
                    model_mem[8'((a + {{20{w[31]}}, w[31:25], w[11:7]}) >> 2)] = b;
                    wr = 1'b0;
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if ((a == b) != w[12]) begin
                        pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                        continue;
                    end
                end
                default: begin   // jal
                    imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                    if (imm == '0)
                        break;
                    res = pc + 32'd4;
                end
            endcase
            if (wr && rd != 0) begin
                regs[rd] = res;
                exp_pc.push_back(pc);
                exp_rd.push_back(word_t'(rd));
                exp_data.push_back(res);
                count++;
            end
            pc = (w[6:0] == 7'b1101111) ? pc + imm : pc + 32'd4;
        end
        return count;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic build_program();
        int          sel;
        logic [2:0]  f3;
        for (int i = 0; i < mem_words; i++)
            img[i] = (i * 32'h0101_0101) ^ 32'h5a00_00c3;   // data fill
        n_prog = 0;
        for (int i = 1; i < 32; i++)
            emit(enc_i(7'b0010011, 3'b000, i, 0, 73 * i - 1100));   // known start values
        emit(enc_i(7'b0010011, 3'b000, 1, 0, 5));
        emit(enc_i(7'b0010011, 3'b000, 2, 0, -3));
        emit(enc_r(7'h00, 3'b000, 3, 1, 2));   // add
        emit(enc_r(7'h20, 3'b000, 4, 1, 2));   // sub
        emit(enc_r(7'h00, 3'b111, 5, 1, 2));
        emit(enc_r(7'h00, 3'b110, 6, 1, 2));
        emit(enc_r(7'h00, 3'b100, 7, 1, 2));
        emit(enc_r(7'h00, 3'b010, 8, 2, 1));
        emit(enc_r(7'h00, 3'b010, 9, 1, 2));
        emit({20'habcde, 5'd10, 7'b0110111});
        emit(enc_i(7'b0010011, 3'b000, 31, 0, 32'h200));   // data base
        emit(enc_s(3, 31, 0));
        emit(enc_i(7'b0000011, 3'b010, 11, 31, 0));
        emit(enc_s(10, 31, 4));
        emit(enc_i(7'b0000011, 3'b010, 12, 31, 4));
        emit(enc_b(3'b000, 1, 1, 8));   // beq taken
        emit(enc_i(7'b0010011, 3'b000, 13, 0, 99));   // wrong path
        emit(enc_b(3'b001, 1, 1, 8));   // bne not taken
        emit(enc_i(7'b0010011, 3'b000, 14, 0, 7));
        emit(enc_b(3'b000, 1, 2, 8));   // beq not taken
        emit(enc_b(3'b001, 1, 2, 8));   // bne taken
        emit(enc_i(7'b0010011, 3'b000, 15, 0, 11));
        emit(enc_j(16, 8));
        emit(enc_i(7'b0010011, 3'b000, 17, 0, 12));
        emit(enc_i(7'b0010011, 3'b000, 18, 0, 1));
        for (int i = 0; i < 4; i++)
            emit(enc_r(7'h00, 3'b000, 18, 18, 18));   // dependent chain
        emit(enc_r(7'h20, 3'b000, 19, 18, 1));
        for (int i = 0; i < 48; i++) begin
            sel = rnd(8);
            case (sel)
                0, 1, 2, 3: emit(enc_r((rnd(2) == 0) ? 7'h00 : 7'h20, 3'b000,
                                       1 + rnd(30), rnd(32), rnd(32)));
                4: begin
                    case (rnd(4))
                        0:       f3 = 3'b010;   // slt
                        1:       f3 = 3'b100;
                        2:       f3 = 3'b110;
                        default: f3 = 3'b111;
                    endcase
                    emit(enc_r(7'h00, f3, 1 + rnd(30), rnd(32), rnd(32)));
                end
                5: emit(enc_i(7'b0010011, 3'b000, 1 + rnd(30), rnd(32), rnd(4096) - 2048));
                6: emit(enc_s(rnd(31), 31, 4 * rnd(64)));
                default: emit(enc_i(7'b0000011, 3'b010, 1 + rnd(30), 31, 4 * rnd(64)));
            endcase
        end
        emit(enc_i(7'b0010011, 3'b000, 1, 0, 1));   // last retire comes after every store
        emit(enc_j(0, 0));
    endtask

    // memory model with random ack delay
    always @(posedge clk) begin
        if (rst) begin
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            delay = -1;
            for (int i = 0; i < mem_words; i++)
                mem[i] <= img[i];
        end else if (mem_req && !mem_ack) begin
            if (delay < 0)
                delay = rnd(4);
            if (delay == 0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem[mem_addr[9:2]];
                if (mem_we)
                    mem[mem_addr[9:2]] <= mem_wdata;
                delay = -1;
            end else begin
                delay = delay - 1;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack <= 1'b0;
        end
    end

    always @(posedge clk)
        cycles <= rst ? 0 : cycles + 1;

    // compare process samples away from the active edge
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            if (exp_idx >= n_exp) begin
                errors++;
                $display("retire seen after the whole expected sequence, pc %h", retire_pc);
            end else begin
                check_value("retire_pc", retire_pc, exp_pc[exp_idx]);
                check_value("retire_rd", word_t'(retire_rd), exp_rd[exp_idx]);
                check_value("retire_data", retire_data, exp_data[exp_idx]);
                exp_idx++;
            end
        end
    end

    initial begin
        rst       = 1'b1;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        errors    = 0;
        exp_idx   = 0;
        cycles    = 0;
        build_program();
        n_exp = run_model();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (exp_idx < n_exp && cycles < 40 * n_exp)
            @(posedge clk);
        if (exp_idx < n_exp) begin
            errors++;
            $display("timeout after %0d cycles with %0d of %0d retires seen",
                     cycles, exp_idx, n_exp);
        end
        for (int i = mem_words / 2; i < mem_words; i++)
            check_value($sformatf("mem[%0d]", i), mem[i], model_mem[i]);
        $display("retires checked %0d of %0d, errors %0d", exp_idx, n_exp, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* core_top.sv */
`timescale 1ns/10ps
module core_top import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      mem_ack,
    input  word_t     mem_rdata,
    output logic      mem_req,
    output logic      mem_we,
    output addr_t     mem_addr,
    output word_t     mem_wdata,
    output logic      retire_valid,
    output addr_t     retire_pc,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);
    logic      if_valid, if_ready, im_req, im_ack, redirect, flush;
    inst_t     if_inst;
    addr_t     if_pc, im_addr, redirect_pc;
    word_t     im_rdata;
    logic      id_valid, id_ready, hazard, id_rw_en;
    inst_t     id_inst;
    addr_t     id_pc;
    word_t     id_oprand1, id_oprand2, id_lsu_data;
    alu_op_e   id_alu_op;
    lsu_op_e   id_lsu_op;
    br_op_e    id_br_op;
    reg_addr_t id_rw_addr;
    logic      ex_valid, ns_ready, ex_rw_en;
    inst_t     ex_inst;
    addr_t     ex_pc;
    word_t     ex_oprand1, ex_oprand2, ex_lsu_data;
    alu_op_e   ex_alu_op;
    lsu_op_e   ex_lsu_op;
    br_op_e    ex_br_op;
    reg_addr_t ex_rw_addr;
    logic      lsu_start, lsu_we, lsu_done, dm_req, dm_we, dm_ack;
    addr_t     lsu_addr, dm_addr;
    word_t     lsu_wdata, lsu_rdata, dm_wdata, dm_rdata;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .if_ready(if_ready), .redirect(redirect),
        .redirect_pc(redirect_pc), .ack(im_ack), .rdata(im_rdata), .req(im_req),
        .addr(im_addr), .if_valid(if_valid), .if_inst(if_inst), .if_pc(if_pc)
    );

    // retire port doubles as the write-back path
    decode_stage u_decode (
        .clk(clk), .rst(rst), .if_valid(if_valid), .if_inst(if_inst), .if_pc(if_pc),
        .id_ready(id_ready), .wb_en(retire_valid), .wb_addr(retire_rd),
        .wb_data(retire_data), .flush(flush), .if_ready(if_ready), .id_valid(id_valid),
        .hazard(hazard), .inst(id_inst), .pc(id_pc), .oprand1(id_oprand1),
        .oprand2(id_oprand2), .lsu_data(id_lsu_data), .alu_op(id_alu_op),
        .lsu_op(id_lsu_op), .br_op(id_br_op), .rw_addr(id_rw_addr), .rw_en(id_rw_en)
    );

    id_ex u_id_ex (
        .clk(clk), .rst(rst), .ls_valid(id_valid), .ns_ready(ns_ready), .stall(hazard),
        .flush(flush), .id_inst(id_inst), .id_pc(id_pc), .id_oprand1(id_oprand1),
        .id_oprand2(id_oprand2), .id_lsu_data(id_lsu_data), .id_alu_op(id_alu_op),
        .id_lsu_op(id_lsu_op), .id_br_op(id_br_op), .id_rw_addr(id_rw_addr),
        .id_rw_en(id_rw_en), .ts_valid(ex_valid), .ts_ready(id_ready), .ex_inst(ex_inst),
        .ex_pc(ex_pc), .ex_oprand1(ex_oprand1), .ex_oprand2(ex_oprand2),
        .ex_lsu_data(ex_lsu_data), .ex_alu_op(ex_alu_op), .ex_lsu_op(ex_lsu_op),
        .ex_br_op(ex_br_op), .ex_rw_addr(ex_rw_addr), .ex_rw_en(ex_rw_en)
    );

    ex_stage u_ex (
        .clk(clk), .rst(rst), .ex_valid(ex_valid), .inst(ex_inst), .pc(ex_pc),
        .oprand1(ex_oprand1), .oprand2(ex_oprand2), .lsu_data(ex_lsu_data),
        .alu_op(ex_alu_op), .lsu_op(ex_lsu_op), .br_op(ex_br_op), .rw_addr(ex_rw_addr),
        .rw_en(ex_rw_en), .lsu_done(lsu_done), .lsu_rdata(lsu_rdata), .ns_ready(ns_ready),
        .redirect(redirect), .redirect_pc(redirect_pc), .flush(flush),
        .lsu_start(lsu_start), .lsu_we(lsu_we), .lsu_addr(lsu_addr), .lsu_wdata(lsu_wdata),
        .wb_en(retire_valid), .wb_addr(retire_rd), .wb_data(retire_data),
        .retire_pc(retire_pc)
    );

    lsu u_lsu (
        .clk(clk), .rst(rst), .lsu_start(lsu_start), .lsu_we(lsu_we), .lsu_addr(lsu_addr),
        .lsu_wdata(lsu_wdata), .ack(dm_ack), .rdata(dm_rdata), .req(dm_req), .we(dm_we),
        .addr(dm_addr), .wdata(dm_wdata), .lsu_done(lsu_done), .lsu_rdata(lsu_rdata)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst(rst), .dm_req(dm_req), .dm_we(dm_we), .dm_addr(dm_addr),
        .dm_wdata(dm_wdata), .dm_ack(dm_ack), .dm_rdata(dm_rdata), .im_req(im_req),
        .im_addr(im_addr), .im_ack(im_ack), .im_rdata(im_rdata), .mem_ack(mem_ack),
        .mem_rdata(mem_rdata), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata)
    );

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen      = 32;
    localparam int mem_words = 256;   // memory image size, in words

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;

    localparam addr_t reset_pc = 32'h0000_0000;

    // major opcodes of the supported rv32i subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b,   // lui
        alu_link      // jal return address
    } alu_op_e;

    typedef enum logic [1:0] {
        lsu_none,
        lsu_load,
        lsu_store
    } lsu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jal
    } br_op_e;

endpackage

/* decode_stage.sv */
`timescale 1ns/10ps
module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      if_valid,
    input  inst_t     if_inst,
    input  addr_t     if_pc,
    input  logic      id_ready,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  logic      flush,
    output logic      if_ready,
    output logic      id_valid,
    output logic      hazard,
    output inst_t     inst,
    output addr_t     pc,
    output word_t     oprand1,
    output word_t     oprand2,
    output word_t     lsu_data,
    output alu_op_e   alu_op,
    output lsu_op_e   lsu_op,
    output br_op_e    br_op,
    output reg_addr_t rw_addr,
    output logic      rw_en
);
    word_t       rf [32];
    logic [31:0] pending;   // write outstanding, per register
    opcode_e     opcode;
    reg_addr_t   rs1, rs2, rd;
    word_t       rs1_val, rs2_val, imm_i, imm_s, imm_u;
    logic        writes, use_rs1, use_rs2;

    assign opcode  = opcode_e'(if_inst[6:0]);
    assign rs1     = if_inst[19:15];
    assign rs2     = if_inst[24:20];
    assign rd      = if_inst[11:7];
    assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];
    assign imm_i   = {{20{if_inst[31]}}, if_inst[31:20]};
    assign imm_s   = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
    assign imm_u   = {if_inst[31:12], 12'h000};

    always_comb begin
        alu_op   = alu_add;
        lsu_op   = lsu_none;
        br_op    = br_none;
        oprand1  = rs1_val;
        oprand2  = rs2_val;
        lsu_data = rs2_val;
        writes   = 1'b0;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        case (opcode)
            op_reg: begin
                writes  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (if_inst[14:12])
                    3'b000:  alu_op = if_inst[30] ? alu_sub : alu_add;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: alu_op = alu_add;
                endcase
            end
            op_imm: begin   // addi only
                writes  = 1'b1;
                use_rs1 = 1'b1;
                oprand2 = imm_i;
            end
            op_lui: begin
                writes  = 1'b1;
                alu_op  = alu_pass_b;
                oprand2 = imm_u;
            end
            op_load: begin
                writes  = 1'b1;
                use_rs1 = 1'b1;
                lsu_op  = lsu_load;
                oprand2 = imm_i;
            end
            op_store: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                lsu_op  = lsu_store;
                oprand2 = imm_s;
            end
            op_branch: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                br_op   = if_inst[12] ? br_bne : br_beq;
            end
            op_jal: begin
                writes = 1'b1;
                alu_op = alu_link;
                br_op  = br_jal;
            end
            default: ;   // unsupported, flows through as a nop
        endcase
    end

    assign inst     = if_inst;
    assign pc       = if_pc;
    assign rw_addr  = rd;
    assign rw_en    = writes && (rd != '0);
    // waw included so an older write cannot clear a younger pending bit
    assign hazard   = if_valid && ((use_rs1 && pending[rs1]) || (use_rs2 && pending[rs2])
                      || (writes && pending[rd]));
    assign id_valid = if_valid && !hazard;
    assign if_ready = id_ready && !hazard;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wb_en)
                pending[wb_addr] <= 1'b0;
            if (if_valid && if_ready && !flush && rw_en)
                pending[rd] <= 1'b1;   // set wins over a same-cycle clear
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en)
            rf[wb_addr] <= wb_data;
    end

endmodule

/* ex_stage.sv */
`timescale 1ns/10ps
module ex_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ex_valid,
    input  inst_t     inst,
    input  addr_t     pc,
    input  word_t     oprand1,
    input  word_t     oprand2,
    input  word_t     lsu_data,
    input  alu_op_e   alu_op,
    input  lsu_op_e   lsu_op,
    input  br_op_e    br_op,
    input  reg_addr_t rw_addr,
    input  logic      rw_en,
    input  logic      lsu_done,
    input  word_t     lsu_rdata,
    output logic      ns_ready,
    output logic      redirect,
    output addr_t     redirect_pc,
    output logic      flush,
    output logic      lsu_start,
    output logic      lsu_we,
    output addr_t     lsu_addr,
    output word_t     lsu_wdata,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output addr_t     retire_pc
);
    word_t alu_result;
    addr_t imm_b, imm_j;
    logic  taken, is_mem, mem_busy;

    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (alu_op)
            alu_add:    alu_result = oprand1 + oprand2;
            alu_sub:    alu_result = oprand1 - oprand2;
            alu_and:    alu_result = oprand1 & oprand2;
            alu_or:     alu_result = oprand1 | oprand2;
            alu_xor:    alu_result = oprand1 ^ oprand2;
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(oprand1) < $signed(oprand2)};
            alu_pass_b: alu_result = oprand2;
            alu_link:   alu_result = pc + 32'd4;
        endcase
    end

    always_comb begin
        taken       = 1'b0;
        redirect_pc = pc + imm_b;
        case (br_op)
            br_beq: taken = (oprand1 == oprand2);
            br_bne: taken = (oprand1 != oprand2);
            br_jal: begin
                taken       = 1'b1;
                redirect_pc = pc + imm_j;
            end
            default: ;
        endcase
    end

    assign redirect  = ex_valid && taken;
    assign flush     = redirect;   // kills the word id_ex would take next
    assign is_mem    = ex_valid && (lsu_op != lsu_none);
    assign ns_ready  = !is_mem || lsu_done;
    assign lsu_start = is_mem && !mem_busy;
    assign lsu_we    = (lsu_op == lsu_store);
    assign lsu_addr  = alu_result;
    assign lsu_wdata = lsu_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_busy <= 1'b0;
            wb_en    <= 1'b0;
        end else begin
            if (lsu_start)
                mem_busy <= 1'b1;
            else if (lsu_done)
                mem_busy <= 1'b0;
            wb_en <= ex_valid && ns_ready && rw_en;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && ns_ready) begin
            wb_addr   <= rw_addr;
            wb_data   <= (lsu_op == lsu_load) ? lsu_rdata : alu_result;
            retire_pc <= pc;
        end
    end

endmodule

/* fetch_unit.sv */
`timescale 1ns/10ps
module fetch_unit import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  if_ready,
    input  logic  redirect,
    input  addr_t redirect_pc,
    input  logic  ack,
    input  word_t rdata,
    output logic  req,
    output addr_t addr,
    output logic  if_valid,
    output inst_t if_inst,
    output addr_t if_pc
);
    typedef enum logic [1:0] {f_idle, f_req, f_ack_low, f_hold} state_e;

    state_e state;
    addr_t  pc;
    logic   drop;   // word in flight is on the wrong path

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= f_idle;
            pc    <= reset_pc;
            drop  <= 1'b0;
        end else begin
            case (state)
                f_idle: state <= f_req;
                f_req: if (ack) state <= f_ack_low;
                f_ack_low: if (!ack) begin
                    state <= drop ? f_idle : f_hold;
                    drop  <= 1'b0;
                end
                f_hold: if (if_ready) begin
                    pc    <= pc + 32'd4;
                    state <= f_idle;
                end
            endcase
            if (redirect) begin
                pc <= redirect_pc;
                if (state == f_req || (state == f_ack_low && ack))
                    drop <= 1'b1;   // handshake must close before refetch
                else
                    state <= f_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == f_idle)
            addr <= pc;   // held for the whole handshake
        if (state == f_req && ack)
            if_inst <= rdata;
    end

    assign req      = (state == f_req);
    assign if_valid = (state == f_hold);
    assign if_pc    = pc;

endmodule

/* id_ex.sv */
`timescale 1ns/10ps
module id_ex import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ls_valid,   // last stage valid
    input  logic      ns_ready,   // next stage ready
    input  logic      stall,
    input  logic      flush,
    input  inst_t     id_inst,
    input  addr_t     id_pc,
    input  word_t     id_oprand1,
    input  word_t     id_oprand2,
    input  word_t     id_lsu_data,
    input  alu_op_e   id_alu_op,
    input  lsu_op_e   id_lsu_op,
    input  br_op_e    id_br_op,
    input  reg_addr_t id_rw_addr,
    input  logic      id_rw_en,
    output logic      ts_valid,
    output logic      ts_ready,
    output inst_t     ex_inst,
    output addr_t     ex_pc,
    output word_t     ex_oprand1,
    output word_t     ex_oprand2,
    output word_t     ex_lsu_data,
    output alu_op_e   ex_alu_op,
    output lsu_op_e   ex_lsu_op,
    output br_op_e    ex_br_op,
    output reg_addr_t ex_rw_addr,
    output logic      ex_rw_en
);
    logic load;

    assign ts_ready = ns_ready;
    assign load     = ls_valid && ns_ready && !stall;

    always_ff @(posedge clk) begin
        if (rst || flush)
            ts_valid <= 1'b0;
        else if (load)
            ts_valid <= 1'b1;
        else if (ns_ready)
            ts_valid <= 1'b0;   // consumed, nothing new behind it
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ex_inst     <= id_inst;
            ex_pc       <= id_pc;
            ex_oprand1  <= id_oprand1;
            ex_oprand2  <= id_oprand2;
            ex_lsu_data <= id_lsu_data;
            ex_alu_op   <= id_alu_op;
            ex_lsu_op   <= id_lsu_op;
            ex_br_op    <= id_br_op;
            ex_rw_addr  <= id_rw_addr;
            ex_rw_en    <= id_rw_en;
        end
    end

endmodule

/* lsu.sv */
`timescale 1ns/10ps
module lsu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  lsu_start,
    input  logic  lsu_we,
    input  addr_t lsu_addr,
    input  word_t lsu_wdata,
    input  logic  ack,
    input  word_t rdata,
    output logic  req,
    output logic  we,
    output addr_t addr,
    output word_t wdata,
    output logic  lsu_done,
    output word_t lsu_rdata
);
    typedef enum logic [1:0] {s_idle, s_req, s_ack_low} state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= s_idle;
            lsu_done <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            case (state)
                s_idle: if (lsu_start) state <= s_req;
                s_req: if (ack) state <= s_ack_low;
                s_ack_low: if (!ack) begin
                    state    <= s_idle;
                    lsu_done <= 1'b1;   // one cycle pulse
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && lsu_start) begin
            we    <= lsu_we;
            addr  <= lsu_addr;
            wdata <= lsu_wdata;
        end
        if (state == s_req && ack)
            lsu_rdata <= rdata;
    end

    assign req = (state == s_req);

endmodule

/* mem_arbiter.sv */
`timescale 1ns/10ps
module mem_arbiter import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  dm_req,   // load/store unit
    input  logic  dm_we,
    input  addr_t dm_addr,
    input  word_t dm_wdata,
    output logic  dm_ack,
    output word_t dm_rdata,
    input  logic  im_req,   // fetch
    input  addr_t im_addr,
    output logic  im_ack,
    output word_t im_rdata,
    input  logic  mem_ack,
    input  word_t mem_rdata,
    output logic  mem_req,
    output logic  mem_we,
    output addr_t mem_addr,
    output word_t mem_wdata
);
    typedef enum logic [1:0] {own_none, own_data, own_inst} owner_e;

    owner_e owner;

    // released only once req and ack are both low again
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= own_none;
        end else begin
            case (owner)
                own_none: begin
                    if (dm_req)
                        owner <= own_data;   // data side first
                    else if (im_req)
                        owner <= own_inst;
                end
                own_data: if (!dm_req && !mem_ack) owner <= own_none;
                own_inst: if (!im_req && !mem_ack) owner <= own_none;
                default:  owner <= own_none;
            endcase
        end
    end

    assign mem_req   = (owner == own_data && dm_req) || (owner == own_inst && im_req);
    assign mem_we    = (owner == own_data) && dm_we;
    assign mem_addr  = (owner == own_inst) ? im_addr : dm_addr;
    assign mem_wdata = dm_wdata;
    assign dm_ack    = (owner == own_data) && mem_ack;
    assign im_ack    = (owner == own_inst) && mem_ack;
    assign dm_rdata  = mem_rdata;
    assign im_rdata  = mem_rdata;

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module core_tb -f src.f -o core_sim \
    && ./obj_dir/core_sim > sim.log 2>&1 || exit 1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0

/* src.f */
cpu_pkg.sv
fetch_unit.sv
decode_stage.sv
id_ex.sv
ex_stage.sv
lsu.sv
mem_arbiter.sv
core_top.sv
core_chk.sv
core_tb.sv
